// ==== logic/cpu_isa_pkg.sv ====
// ALU operation codes, command kinds, flag bit positions, microstep numbers, ALU and H modes
package cpu_isa_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_ADC = 3'd1,
        OP_SUB = 3'd2,
        OP_SBC = 3'd3,
        OP_AND = 3'd4,
        OP_XOR = 3'd5,
        OP_OR  = 3'd6,
        OP_CP  = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        LOAD_A  = 2'd0,
        LOAD_IX = 2'd1,
        LOAD_IY = 2'd2,
        ALU_OP  = 2'd3
    } cmd_kind_t;

    localparam int FLAG_S  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_H  = 4;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N  = 1;
    localparam int FLAG_C  = 0;

    localparam logic [3:0] STEP_IDLE = 4'd0;
    localparam logic [3:0] STEP_ADDR = 4'd3;   // Index plus displacement
    localparam logic [3:0] STEP_RA0  = 4'd8;
    localparam logic [3:0] STEP_RA1  = 4'd9;
    localparam logic [3:0] STEP_RA2  = 4'd10;
    localparam logic [3:0] STEP_EXEC = 4'd11;

    localparam logic [1:0] LSEL_ARITH = 2'd0;
    localparam logic [1:0] LSEL_AND   = 2'd1;
    localparam logic [1:0] LSEL_XOR   = 2'd2;
    localparam logic [1:0] LSEL_OR    = 2'd3;

    localparam logic [1:0] HMODE_ARITH = 2'd0;  // Nibble carry or borrow
    localparam logic [1:0] HMODE_ZERO  = 2'd1;
    localparam logic [1:0] HMODE_ONE   = 2'd2;

endpackage

// ==== logic/exec_bus_pkg.sv ====
// Command, response, memory request and control word structs
package exec_bus_pkg;

    typedef struct packed {
        cpu_isa_pkg::cmd_kind_t kind;
        cpu_isa_pkg::alu_op_t   op;
        logic signed [7:0]      disp;
        logic [15:0]            value;   // Low byte for A, bit 0 picks IY on ALU ops
    } exec_cmd_t;

    typedef struct packed {
        logic [7:0] a;
        logic [7:0] f;
    } exec_rsp_t;

    typedef struct packed {
        logic [15:0] addr;
    } mem_rd_t;

    typedef struct packed {
        logic                 addr_latch;
        logic                 mem_req_set;
        logic                 mem_req_clr;
        cpu_isa_pkg::alu_op_t alu_op;
        logic                 write_a;
        logic                 write_f;
        logic                 carry_in_use;
        logic                 subtract;
        logic [1:0]           logic_sel;
        logic [1:0]           flag_h_mode;
        logic                 flag_pv_parity;
        logic                 reset_step;
    } alu_ctrl_t;

endpackage

// ==== logic/ucode_sequencer.sv ====
`timescale 1ns/1ps
// Microstep counter, command handshake, memory handshake and operand capture
module ucode_sequencer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cmd_req,
    input  exec_bus_pkg::exec_cmd_t cmd,
    output logic                    cmd_ack,
    input  exec_bus_pkg::alu_ctrl_t ctrl,
    output logic [3:0]              step,
    output cpu_isa_pkg::cmd_kind_t  load_kind,
    output logic                    load_en,
    output logic                    mem_req,
    input  logic                    mem_ack,
    input  logic [7:0]              mem_data,
    output logic [7:0]              operand,
    output cpu_isa_pkg::alu_op_t    op
);
    import cpu_isa_pkg::*;

    logic       busy;
    logic       accept;
    logic       finish;
    logic [1:0] load_pipe;  // Write strobe, then ack
    logic [3:0] step_nxt;

    assign accept  = cmd_req && !busy && !cmd_ack;
    assign load_en = load_pipe[0];
    assign finish  = load_pipe[1] || ctrl.reset_step;

    always_comb begin
        step_nxt = step;
        case (step)
            STEP_IDLE: if (accept && cmd.kind == ALU_OP) step_nxt = STEP_ADDR;
            STEP_ADDR: step_nxt = STEP_RA0;
            STEP_RA0:  step_nxt = STEP_RA1;
            STEP_RA1:  if (mem_ack) step_nxt = STEP_RA2;     // Data is on the bus
            STEP_RA2:  if (!mem_ack) step_nxt = STEP_EXEC;   // Ack released
            STEP_EXEC: if (ctrl.reset_step) step_nxt = STEP_IDLE;
            default:   step_nxt = STEP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step      <= STEP_IDLE;
            busy      <= 1'b0;
            cmd_ack   <= 1'b0;
            load_pipe <= 2'b00;
            mem_req   <= 1'b0;
            load_kind <= LOAD_A;
            op        <= OP_ADD;
        end else begin
            step      <= step_nxt;
            load_pipe <= {load_pipe[0], accept && cmd.kind != ALU_OP};

            if (accept) begin
                busy      <= 1'b1;
                load_kind <= cmd.kind;
                op        <= cmd.op;
            end else if (finish) begin
                busy <= 1'b0;
            end

            if (finish) begin
                cmd_ack <= 1'b1;
            end else if (!cmd_req) begin
                cmd_ack <= 1'b0;   // Return to zero
            end

            if (ctrl.mem_req_set) begin
                mem_req <= 1'b1;
            end else if (ctrl.mem_req_clr && mem_ack) begin
                mem_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.mem_req_clr && mem_ack) begin
            operand <= mem_data;
        end
    end

endmodule

// ==== logic/alu_op_decoder.sv ====
`timescale 1ns/1ps
// Decoder from operation and microstep to the ALU control word
module alu_op_decoder (
    input  logic [3:0]              step,
    input  cpu_isa_pkg::alu_op_t    op,
    output exec_bus_pkg::alu_ctrl_t ctrl
);
    import cpu_isa_pkg::*;

    logic is_exec;

    assign is_exec = (step == STEP_EXEC);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op      = OP_ADD;   // Address add in the ADDR step
        ctrl.addr_latch  = (step == STEP_ADDR);
        ctrl.mem_req_set = (step == STEP_RA0);
        ctrl.mem_req_clr = (step == STEP_RA1);

        if (is_exec) begin
            ctrl.alu_op     = op;
            ctrl.write_a    = (op != OP_CP);   // CP only sets flags
            ctrl.write_f    = 1'b1;
            ctrl.reset_step = 1'b1;

            case (op)
                OP_ADC: begin
                    ctrl.carry_in_use = 1'b1;
                end
                OP_SUB, OP_CP: begin
                    ctrl.subtract = 1'b1;
                end
                OP_SBC: begin
                    ctrl.subtract     = 1'b1;
                    ctrl.carry_in_use = 1'b1;
                end
                OP_AND: begin
                    ctrl.logic_sel      = LSEL_AND;
                    ctrl.flag_h_mode    = HMODE_ONE;
                    ctrl.flag_pv_parity = 1'b1;
                end
                OP_XOR: begin
                    ctrl.logic_sel      = LSEL_XOR;
                    ctrl.flag_h_mode    = HMODE_ZERO;
                    ctrl.flag_pv_parity = 1'b1;
                end
                OP_OR: begin
                    ctrl.logic_sel      = LSEL_OR;
                    ctrl.flag_h_mode    = HMODE_ZERO;
                    ctrl.flag_pv_parity = 1'b1;
                end
                default: begin
                    ctrl.logic_sel   = LSEL_ARITH;   // Plain ADD
                    ctrl.flag_h_mode = HMODE_ARITH;
                end
            endcase
        end
    end

endmodule

// ==== logic/index_address_unit.sv ====
`timescale 1ns/1ps
// IX and IY registers, displacement adder and memory address latch
module index_address_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    load_en,
    input  cpu_isa_pkg::cmd_kind_t  load_kind,
    input  logic [15:0]             value,
    input  logic [7:0]              disp,
    input  logic                    use_iy,
    input  exec_bus_pkg::alu_ctrl_t ctrl,
    output exec_bus_pkg::mem_rd_t   mem
);
    import cpu_isa_pkg::*;

    logic [15:0] ix;
    logic [15:0] iy;
    logic [15:0] base;
    logic [15:0] disp_ext;

    assign base     = use_iy ? iy : ix;
    assign disp_ext = {{8{disp[7]}}, disp};   // Signed offset

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ix <= 16'h0000;
            iy <= 16'h0000;
        end else if (load_en) begin
            if (load_kind == LOAD_IX) begin
                ix <= value;
            end
            if (load_kind == LOAD_IY) begin
                iy <= value;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem.addr <= 16'h0000;
        end else if (ctrl.addr_latch) begin
            mem.addr <= base + disp_ext;   // Wraps at 16 bits
        end
    end

endmodule

// ==== logic/alu_core.sv ====
`timescale 1ns/1ps
// 8-bit adder-subtractor with half carry and overflow, plus logic unit
module alu_core (
    input  logic [7:0]              a,
    input  logic [7:0]              b,
    input  logic                    carry_in,
    input  exec_bus_pkg::alu_ctrl_t ctrl,
    output logic [7:0]              result,
    output logic                    carry,
    output logic                    half,
    output logic                    overflow
);
    import cpu_isa_pkg::*;

    logic       cin;
    logic [7:0] b_eff;
    logic [4:0] low_sum;
    logic [8:0] full_sum;

    // Subtract as a + ~b + ~c
    assign cin   = (ctrl.carry_in_use & carry_in) ^ ctrl.subtract;
    assign b_eff = ctrl.subtract ? ~b : b;

    assign low_sum  = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0000, cin};
    assign full_sum = {1'b0, a} + {1'b0, b_eff} + {8'h00, cin};

    // Borrows come out inverted on subtract
    assign carry    = full_sum[8] ^ ctrl.subtract;
    assign half     = low_sum[4] ^ ctrl.subtract;
    assign overflow = (a[7] == b_eff[7]) && (full_sum[7] != a[7]);

    always_comb begin
        case (ctrl.logic_sel)
            LSEL_AND: result = a & b;
            LSEL_XOR: result = a ^ b;
            LSEL_OR:  result = a | b;
            default:  result = full_sum[7:0];
        endcase
    end

endmodule

// ==== logic/accum_flag_unit.sv ====
`timescale 1ns/1ps
// Accumulator and flag registers with per-operation flag selection
module accum_flag_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    load_en,
    input  cpu_isa_pkg::cmd_kind_t  load_kind,
    input  logic [7:0]              value,
    input  logic [7:0]              result,
    input  logic                    carry,
    input  logic                    half,
    input  logic                    overflow,
    input  exec_bus_pkg::alu_ctrl_t ctrl,
    output logic [7:0]              a,
    output logic [7:0]              f
);
    import cpu_isa_pkg::*;

    logic [7:0] f_nxt;

    always_comb begin
        f_nxt = 8'h00;   // Bits 3 and 5 stay clear
        f_nxt[FLAG_S] = result[7];
        f_nxt[FLAG_Z] = (result == 8'h00);
        case (ctrl.flag_h_mode)
            HMODE_ARITH: f_nxt[FLAG_H] = half;
            HMODE_ONE:   f_nxt[FLAG_H] = 1'b1;
            default:     f_nxt[FLAG_H] = 1'b0;
        endcase
        f_nxt[FLAG_PV] = ctrl.flag_pv_parity ? ~^result : overflow;   // Even parity
        f_nxt[FLAG_N]  = ctrl.subtract;
        f_nxt[FLAG_C]  = (ctrl.logic_sel == LSEL_ARITH) && carry;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a <= 8'h00;
            f <= 8'h00;
        end else begin
            if (load_en && load_kind == LOAD_A) begin
                a <= value;
            end else if (ctrl.write_a) begin
                a <= result;
            end
            if (ctrl.write_f) begin
                f <= f_nxt;
            end
        end
    end

endmodule

// ==== logic/indexed_alu_top.sv ====
`timescale 1ns/1ps
// Top level of the indexed ALU execution unit
module indexed_alu_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cmd_req,
    input  exec_bus_pkg::exec_cmd_t cmd,
    output logic                    cmd_ack,
    output exec_bus_pkg::exec_rsp_t rsp,
    output logic                    mem_req,
    output exec_bus_pkg::mem_rd_t   mem,
    input  logic                    mem_ack,
    input  logic [7:0]              mem_data
);
    import cpu_isa_pkg::*;
    import exec_bus_pkg::*;

    alu_ctrl_t  ctrl;
    cmd_kind_t  load_kind;
    alu_op_t    op;
    logic [3:0] step;
    logic       load_en;
    logic [7:0] operand;
    logic [7:0] result;
    logic       carry;
    logic       half;
    logic       overflow;
    logic [7:0] a;
    logic [7:0] f;

    assign rsp.a = a;
    assign rsp.f = f;

    ucode_sequencer ucode_sequencer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .ctrl      (ctrl),
        .step      (step),
        .load_kind (load_kind),
        .load_en   (load_en),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data),
        .operand   (operand),
        .op        (op)
    );

    alu_op_decoder alu_op_decoder_inst (
        .step (step),
        .op   (op),
        .ctrl (ctrl)
    );

    index_address_unit index_address_unit_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .load_en   (load_en),
        .load_kind (load_kind),
        .value     (cmd.value),
        .disp      (cmd.disp),
        .use_iy    (cmd.value[0]),   // Stands in for the FD prefix
        .ctrl      (ctrl),
        .mem       (mem)
    );

    alu_core alu_core_inst (
        .a        (a),
        .b        (operand),
        .carry_in (f[FLAG_C]),
        .ctrl     (ctrl),
        .result   (result),
        .carry    (carry),
        .half     (half),
        .overflow (overflow)
    );

    accum_flag_unit accum_flag_unit_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .load_en   (load_en),
        .load_kind (load_kind),
        .value     (cmd.value[7:0]),
        .result    (result),
        .carry     (carry),
        .half      (half),
        .overflow  (overflow),
        .ctrl      (ctrl),
        .a         (a),
        .f         (f)
    );

endmodule

// ==== sim/tb_indexed_alu.sv ====
`timescale 1ns/1ps
// Directed testbench for the indexed ALU unit with memory model and reference model
module tb_indexed_alu;
    import cpu_isa_pkg::*;
    import exec_bus_pkg::*;

    localparam int CMD_TIMEOUT  = 60;
    localparam int MEM_TIMEOUT  = 20;
    localparam int LOAD_LATENCY = 3;   // Negedges from request drive to ack

    logic      clk;
    logic      arst_n;
    logic      cmd_req;
    exec_cmd_t cmd;
    logic      cmd_ack;
    exec_rsp_t rsp;
    logic      mem_req;
    mem_rd_t   mem;
    logic      mem_ack;
    logic [7:0] mem_data;

    int          seed = 32'h6805_6be7;
    int          errors = 0;
    int          commands = 0;
    int          handshakes = 0;
    int          hs_at_ack = 0;
    int          extra_delay = 0;
    logic [15:0] last_addr = 16'h0000;
    exec_rsp_t   last_rsp = '0;
    logic [7:0]  ref_a = 8'h00;
    logic [7:0]  ref_f = 8'h00;
    logic [15:0] ref_ix = 16'h0000;
    logic [15:0] ref_iy = 16'h0000;

    indexed_alu_top indexed_alu_top_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .cmd_req  (cmd_req),
        .cmd      (cmd),
        .cmd_ack  (cmd_ack),
        .rsp      (rsp),
        .mem_req  (mem_req),
        .mem      (mem),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        errors++;
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
    endtask

    task automatic report_word(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        errors++;
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    function automatic logic [7:0] mem_byte(input logic [15:0] addr);
        return addr[7:0] ^ addr[15:8] ^ 8'h3c;
    endfunction

    // Returns {new A, new F}
    function automatic logic [15:0] ref_alu(input alu_op_t op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cf);
        int ua;
        int ub;
        int sa;
        int sb;
        int c;
        int r;
        int h;
        int s;
        logic [7:0] res;
        logic [7:0] fl;
        ua = {24'd0, a};
        ub = {24'd0, b};
        sa = {{24{a[7]}}, a};
        sb = {{24{b[7]}}, b};
        c = (op == OP_ADC || op == OP_SBC) ? {31'd0, cf} : 0;
        fl = 8'h00;
        case (op)
            OP_ADD, OP_ADC: begin
                r = ua + ub + c;
                h = (ua % 16) + (ub % 16) + c;
                s = sa + sb + c;
                res = r[7:0];
                fl[FLAG_H]  = (h > 15);
                fl[FLAG_PV] = (s > 127) || (s < -128);
                fl[FLAG_C]  = (r > 255);
            end
            OP_SUB, OP_SBC, OP_CP: begin
                r = ua - ub - c;
                h = (ua % 16) - (ub % 16) - c;
                s = sa - sb - c;
                res = r[7:0];
                fl[FLAG_H]  = (h < 0);   // Borrow from bit 4
                fl[FLAG_PV] = (s > 127) || (s < -128);
                fl[FLAG_N]  = 1'b1;
                fl[FLAG_C]  = (r < 0);
            end
            OP_AND: begin
                res = a & b;
                fl[FLAG_H]  = 1'b1;
                fl[FLAG_PV] = ~^res;
            end
            OP_XOR: begin
                res = a ^ b;
                fl[FLAG_PV] = ~^res;
            end
            default: begin
                res = a | b;
                fl[FLAG_PV] = ~^res;
            end
        endcase
        fl[FLAG_S] = res[7];
        fl[FLAG_Z] = (res == 8'h00);
        return {(op == OP_CP) ? a : res, fl};
    endfunction

    // Answers each read after a random delay and watches the request stay put
    initial begin : mem_model
        int rnd;
        int delay;
        int n;
        mem_ack = 1'b0;
        mem_data = 8'h00;
        forever begin
            @(negedge clk);
            if (mem_req && !mem_ack) begin
                last_addr = mem.addr;
                rnd = $random(seed);
                delay = {30'd0, rnd[1:0]} + extra_delay;
                for (int i = 0; i < delay; i++) begin
                    @(negedge clk);
                    if (mem_req !== 1'b1) report_byte("mem_req", 8'h01, {7'd0, mem_req});
                    if (mem.addr !== last_addr) report_word("mem.addr", last_addr, mem.addr);
                    if (cmd_ack !== 1'b0) report_byte("cmd_ack", 8'h00, {7'd0, cmd_ack});
                end
                @(posedge clk);
                #2;
                mem_ack = 1'b1;
                mem_data = mem_byte(last_addr);
                n = 0;
                @(negedge clk);
                while (mem_req && n < MEM_TIMEOUT) begin
                    @(negedge clk);
                    n++;
                end
                if (mem_req) report_error("mem_req did not fall after mem_ack");
                if (cmd_ack !== 1'b0) report_byte("cmd_ack", 8'h00, {7'd0, cmd_ack});
                @(posedge clk);
                #2;
                mem_ack = 1'b0;
                handshakes++;
            end
        end
    end

    task automatic run_cmd(input exec_cmd_t c, output exec_rsp_t r, output int lat);
        int n;
        @(posedge clk);
        #2;
        cmd = c;
        cmd_req = 1'b1;
        commands++;
        n = 0;
        @(negedge clk);
        while (!cmd_ack && n < CMD_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        lat = n;
        r = rsp;
        hs_at_ack = handshakes;
        if (!cmd_ack) report_error("cmd_ack did not rise for a command");
        @(posedge clk);
        #2;
        cmd_req = 1'b0;
        n = 0;
        @(negedge clk);
        while (cmd_ack && n < CMD_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack) report_error("cmd_ack did not fall after cmd_req dropped");
    endtask

    task automatic load_reg(input cmd_kind_t kind, input logic [15:0] value);
        exec_cmd_t c;
        exec_rsp_t r;
        int        lat;
        c = '0;
        c.kind = kind;
        c.value = value;
        run_cmd(c, r, lat);
        case (kind)
            LOAD_A:  ref_a = value[7:0];
            LOAD_IX: ref_ix = value;
            default: ref_iy = value;
        endcase
        if (lat != LOAD_LATENCY) report_error($sformatf("load took %0d cycles, not 3", lat));
        if (r.a !== ref_a) report_byte("rsp.a", ref_a, r.a);
        if (r.f !== ref_f) report_byte("rsp.f", ref_f, r.f);
    endtask

    task automatic alu_test(input alu_op_t op, input logic [7:0] disp, input logic use_iy);
        exec_cmd_t   c;
        exec_rsp_t   r;
        int          lat;
        int          hs_before;
        logic [15:0] exp_addr;
        logic [15:0] res;
        exp_addr = (use_iy ? ref_iy : ref_ix) + {{8{disp[7]}}, disp};
        res = ref_alu(op, ref_a, mem_byte(exp_addr), ref_f[FLAG_C]);
        ref_a = res[15:8];
        ref_f = res[7:0];
        c = '0;
        c.kind = ALU_OP;
        c.op = op;
        c.disp = disp;
        c.value = {15'd0, use_iy};   // Bit 0 selects IY
        hs_before = handshakes;
        run_cmd(c, r, lat);
        last_rsp = r;
        if (last_addr !== exp_addr) report_word("mem.addr", exp_addr, last_addr);
        if (hs_at_ack != hs_before + 1) report_error("cmd_ack rose before the memory read ended");
        if (r.a !== ref_a) report_byte("rsp.a", ref_a, r.a);
        if (r.f !== ref_f) report_byte("rsp.f", ref_f, r.f);
    endtask

    task automatic test_reset_idle();
        repeat (10) begin
            @(negedge clk);
            if (cmd_ack !== 1'b0) report_byte("cmd_ack", 8'h00, {7'd0, cmd_ack});
            if (mem_req !== 1'b0) report_byte("mem_req", 8'h00, {7'd0, mem_req});
        end
        load_reg(LOAD_A, 16'h00a5);
    endtask

    task automatic test_index_wrap();
        load_reg(LOAD_IX, 16'hfffe);
        alu_test(OP_ADD, 8'h05, 1'b0);   // Wraps to 0003
        alu_test(OP_ADD, 8'hfd, 1'b0);
    endtask

    task automatic test_iy_select();
        load_reg(LOAD_IY, 16'h1234);
        load_reg(LOAD_IX, 16'h5678);
        alu_test(OP_OR, 8'h10, 1'b1);
        alu_test(OP_OR, 8'h10, 1'b0);
    endtask

    task automatic test_all_ops();
        logic [7:0] fixed_a [3];
        int         rnd;
        fixed_a = '{8'h00, 8'h7f, 8'h80};
        load_reg(LOAD_IX, 16'h4000);
        load_reg(LOAD_IY, 16'h8123);
        for (int k = 0; k < 8; k++) begin
            for (int j = 0; j < 3; j++) begin
                rnd = $random(seed);
                load_reg(LOAD_A, {8'h00, fixed_a[j]});
                alu_test(alu_op_t'(k[2:0]), rnd[7:0], rnd[8]);
            end
            for (int j = 0; j < 4; j++) begin
                rnd = $random(seed);
                load_reg(LOAD_A, {8'h00, rnd[23:16]});
                alu_test(alu_op_t'(k[2:0]), rnd[7:0], rnd[8]);
            end
        end
    endtask

    task automatic test_carry_chain();
        load_reg(LOAD_IX, 16'h0000);
        load_reg(LOAD_A, 16'h00ff);
        alu_test(OP_ADD, 8'h3d, 1'b0);   // Operand at 003d is 01
        if (last_rsp.f[FLAG_C] !== 1'b1) begin
            report_byte("rsp.f[C]", 8'h01, {7'd0, last_rsp.f[FLAG_C]});
        end
        alu_test(OP_ADC, 8'h3d, 1'b0);
        load_reg(LOAD_A, 16'h0000);
        alu_test(OP_SUB, 8'h3d, 1'b0);
        alu_test(OP_SBC, 8'h3d, 1'b0);
    endtask

    task automatic test_slow_memory();
        extra_delay = 5;
        load_reg(LOAD_A, 16'h0042);
        alu_test(OP_SUB, 8'h21, 1'b0);
        alu_test(OP_XOR, 8'he0, 1'b1);
        alu_test(OP_CP, 8'h80, 1'b0);
        extra_delay = 0;
    endtask

    initial begin
        arst_n = 1'b0;
        cmd_req = 1'b0;
        cmd = '0;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_reset_idle();
        test_index_wrap();
        test_iy_select();
        test_all_ops();
        test_carry_chain();
        test_slow_memory();
        $display("Commands run: %0d, errors: %0d", commands, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/cpu_isa_pkg.sv
logic/exec_bus_pkg.sv
logic/ucode_sequencer.sv
logic/alu_op_decoder.sv
logic/index_address_unit.sv
logic/alu_core.sv
logic/accum_flag_unit.sv
logic/indexed_alu_top.sv
sim/tb_indexed_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the indexed ALU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_indexed_alu -o tb_indexed_alu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_indexed_alu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
